/* src/arcade_defs.svh */
// arcade console constants for routing, display codes, password and game timing
`ifndef ARC_DEFS_SVH
`define ARC_DEFS_SVH

// button routes
`define ARC_ROUTE_MENU      3'd1
`define ARC_ROUTE_ACCESS    3'd2
`define ARC_ROUTE_GAME      3'd3
`define ARC_ROUTE_SCORES    3'd4

// score display select
`define ARC_DISP_NONE       2'd0
`define ARC_DISP_GAME       2'd1
`define ARC_DISP_SCORES     2'd2

// lcd message codes
`define ARC_LCD_WELCOME     3'd0
`define ARC_LCD_PASSWORD    3'd1
`define ARC_LCD_MENU        3'd2
`define ARC_LCD_PLAYING     3'd3
`define ARC_LCD_SCORES      3'd4

// status led codes
`define ARC_LED_OFF         2'd0
`define ARC_LED_RED         2'd1
`define ARC_LED_GREEN       2'd2

`define ARC_PASSWORD        8'hA5
`define ARC_GO_DELAY_MIN    8
`define ARC_GO_DELAY_BITS   4
`define ARC_SCORE_MAX       255

// go delay lfsr, x^8 + x^6 + x^5 + x^4 + 1
`define ARC_LFSR_SEED       8'h5A
`define ARC_LFSR_TAPS       8'hB8

`endif

/* src/arcade_pkg.sv */
// arcade console package with the controller stage enum and the shared vector types
`default_nettype none

package arcade_pkg;

	// console stages
	typedef enum logic [2:0] {
		ST_INIT,
		ST_ACCESS,
		ST_MENU,
		ST_GAME,
		ST_SCORES
	} pc_state_t;

	typedef logic [2:0] route_t;    // which block gets the buttons
	typedef logic [1:0] disp_sel_t; // score display source
	typedef logic [2:0] lcd_code_t;
	typedef logic [1:0] led_code_t;

	// one reaction score, higher is faster
	typedef logic [7:0] score_t;

	typedef logic [7:0] password_t; // raw switch word

endpackage

`default_nettype wire

/* src/process_control.sv */
// console stage FSM that routes buttons and switches and drives lcd and led codes
`timescale 1ns/1ps
`default_nettype none
`include "arcade_defs.svh"

module process_control (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [2:0]            buttons,
	input  logic                  access_fb,     // granted level
	input  logic                  game_fb,       // round finished
	input  logic                  scoreboard_fb, // scoreboard exit
	output arcade_pkg::route_t    button_route,
	output logic                  switch_route,
	output arcade_pkg::disp_sel_t display_sel,
	output arcade_pkg::lcd_code_t lcd_control,
	output arcade_pkg::led_code_t led_control,
	output logic                  access_clear   // active low logout pulse
);
	import arcade_pkg::*;

	pc_state_t state;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state        <= ST_INIT;
			button_route <= `ARC_ROUTE_MENU;
			switch_route <= 1'b0;
			display_sel  <= `ARC_DISP_NONE;
			lcd_control  <= `ARC_LCD_WELCOME;
			led_control  <= `ARC_LED_OFF;
			access_clear <= 1'b1;
		end else begin
			access_clear <= 1'b1; // only low for the logout cycle
			case (state)
				ST_INIT: begin
					if (buttons[0]) begin
						state        <= ST_ACCESS;
						button_route <= `ARC_ROUTE_ACCESS;
						switch_route <= 1'b1;
						lcd_control  <= `ARC_LCD_PASSWORD;
						led_control  <= `ARC_LED_RED;
					end
				end
				ST_ACCESS: begin
					// wrong entries just stay here
					if (access_fb) begin
						state        <= ST_MENU;
						button_route <= `ARC_ROUTE_MENU;
						switch_route <= 1'b0;
						lcd_control  <= `ARC_LCD_MENU;
						led_control  <= `ARC_LED_GREEN;
					end
				end
				ST_MENU: begin
					if (buttons[2]) begin
						state        <= ST_GAME;
						button_route <= `ARC_ROUTE_GAME;
						display_sel  <= `ARC_DISP_GAME;
						lcd_control  <= `ARC_LCD_PLAYING;
					end else if (buttons[1]) begin
						state        <= ST_SCORES;
						button_route <= `ARC_ROUTE_SCORES;
						display_sel  <= `ARC_DISP_SCORES;
						lcd_control  <= `ARC_LCD_SCORES;
					end else if (buttons[0]) begin
						// logout
						state        <= ST_INIT;
						button_route <= `ARC_ROUTE_MENU;
						display_sel  <= `ARC_DISP_NONE;
						lcd_control  <= `ARC_LCD_WELCOME;
						led_control  <= `ARC_LED_OFF;
						access_clear <= 1'b0;
					end
				end
				ST_GAME: begin
					if (game_fb) begin
						state        <= ST_MENU;
						button_route <= `ARC_ROUTE_MENU;
						display_sel  <= `ARC_DISP_NONE;
						lcd_control  <= `ARC_LCD_MENU;
					end
				end
				ST_SCORES: begin
					if (scoreboard_fb) begin
						state        <= ST_MENU;
						button_route <= `ARC_ROUTE_MENU;
						display_sel  <= `ARC_DISP_NONE;
						lcd_control  <= `ARC_LCD_MENU;
					end
				end
				default: begin
					// back to waiting-stage outputs
					state        <= ST_INIT;
					button_route <= `ARC_ROUTE_MENU;
					switch_route <= 1'b0;
					display_sel  <= `ARC_DISP_NONE;
					lcd_control  <= `ARC_LCD_WELCOME;
					led_control  <= `ARC_LED_OFF;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/access_control.sv */
// password checker that grants access on a matching switch word until logout
`timescale 1ns/1ps
`default_nettype none
`include "arcade_defs.svh"

module access_control (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  access_clear, // active low, from logout
	input  logic [2:0]            buttons,      // routed copy
	input  arcade_pkg::password_t switches,     // zero unless routed
	output logic                  granted
);

	logic submit;
	logic match;

	assign submit = buttons[0];
	assign match  = (switches == `ARC_PASSWORD);

	// granted holds until logout
	always_ff @(posedge clk) begin
		if (!rst) begin
			granted <= 1'b0;
		end else if (!access_clear) begin
			granted <= 1'b0; // logout wins over a same-cycle submit
		end else if (submit && match) begin
			granted <= 1'b1;
		end
		// a mismatch leaves granted as it was
	end

endmodule

`default_nettype wire

/* src/reaction_game.sv */
// reaction game with a random go delay, a reaction counter and the round score
`timescale 1ns/1ps
`default_nettype none
`include "arcade_defs.svh"

module reaction_game (
	input  logic               clk,
	input  logic               rst,
	input  logic [2:0]         buttons,    // routed copy, buttons[2] is the press
	input  arcade_pkg::route_t route,
	output logic               game_go,
	output arcade_pkg::score_t live_count,
	output arcade_pkg::score_t score,
	output logic               done        // one-cycle, score valid
);
	import arcade_pkg::*;

	localparam int DELAY_W = `ARC_GO_DELAY_BITS + 1;

	typedef enum logic [1:0] {
		GM_IDLE,
		GM_WAIT,
		GM_GO
	} gm_state_t;

	gm_state_t          phase;
	logic [7:0]         lfsr;
	logic [DELAY_W-1:0] delay_cnt;
	logic               in_game;
	logic               was_game;
	logic               press;
	score_t             max_score;

	assign in_game   = (route == `ARC_ROUTE_GAME);
	assign press     = buttons[2];
	assign max_score = score_t'(`ARC_SCORE_MAX);

	// galois lfsr, steps every cycle
	always_ff @(posedge clk) begin
		if (!rst) begin
			lfsr <= `ARC_LFSR_SEED;
		end else begin
			lfsr <= {1'b0, lfsr[7:1]} ^ (lfsr[0] ? `ARC_LFSR_TAPS : 8'h00);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			phase      <= GM_IDLE;
			was_game   <= 1'b0;
			delay_cnt  <= '0;
			game_go    <= 1'b0;
			live_count <= '0;
			score      <= '0;
			done       <= 1'b0;
		end else begin
			was_game <= in_game;
			done     <= 1'b0;
			if (!in_game) begin
				phase   <= GM_IDLE;
				game_go <= 1'b0;
			end else begin
				case (phase)
					GM_IDLE: begin
						if (!was_game) begin // first cycle in game mode
							if (press) begin
								score <= '0; // false start
								done  <= 1'b1;
							end else begin
								delay_cnt <= DELAY_W'(`ARC_GO_DELAY_MIN)
									+ DELAY_W'(lfsr[`ARC_GO_DELAY_BITS-1:0]);
								phase     <= GM_WAIT;
							end
						end
					end
					GM_WAIT: begin
						if (press) begin
							score <= '0; // pressed before go
							done  <= 1'b1;
							phase <= GM_IDLE;
						end else if (delay_cnt == DELAY_W'(1)) begin
							game_go    <= 1'b1;
							live_count <= '0;
							phase      <= GM_GO;
						end else begin
							delay_cnt <= delay_cnt - 1'b1;
						end
					end
					GM_GO: begin
						if (press || live_count == max_score) begin
							// timeout lands on max - max = 0
							score   <= max_score - live_count;
							done    <= 1'b1;
							game_go <= 1'b0;
							phase   <= GM_IDLE;
						end else begin
							live_count <= live_count + 1'b1;
						end
					end
					default: begin
						phase   <= GM_IDLE;
						game_go <= 1'b0;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* src/scoreboard.sv */
// scoreboard keeping the last and best scores with a best/last view toggle
`timescale 1ns/1ps
`default_nettype none
`include "arcade_defs.svh"

module scoreboard (
	input  logic               clk,
	input  logic               rst,
	input  logic [2:0]         buttons,     // routed copy
	input  arcade_pkg::route_t route,
	input  logic               done,        // finished round from the game
	input  arcade_pkg::score_t score,
	output arcade_pkg::score_t shown_score,
	output logic               exit_done
);
	import arcade_pkg::*;

	score_t last_score;
	score_t best_score;
	logic   show_best;
	logic   show_best_nxt;
	logic   in_scores;

	assign in_scores = (route == `ARC_ROUTE_SCORES);

	// best is the default view, so outside scoreboard mode it snaps back
	always_comb begin
		show_best_nxt = show_best;
		if (!in_scores) begin
			show_best_nxt = 1'b1;
		end else if (buttons[1]) begin
			show_best_nxt = !show_best;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			last_score  <= '0;
			best_score  <= '0;
			show_best   <= 1'b1;
			shown_score <= '0;
			exit_done   <= 1'b0;
		end else begin
			show_best <= show_best_nxt;
			exit_done <= in_scores && buttons[0];
			if (done) begin
				last_score <= score;
				if (score > best_score) begin
					best_score <= score;
				end
			end
			shown_score <= show_best_nxt ? best_score : last_score;
		end
	end

endmodule

`default_nettype wire

/* src/arcade_top.sv */
// arcade console top, gates buttons and switches by route and selects the score display
`timescale 1ns/1ps
`default_nettype none
`include "arcade_defs.svh"

module arcade_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [2:0]            buttons,
	input  logic [7:0]            switches,
	output arcade_pkg::lcd_code_t lcd_control,
	output arcade_pkg::led_code_t led_control,
	output logic                  game_go,
	output arcade_pkg::score_t    score_display
);
	import arcade_pkg::*;

	route_t    button_route;
	logic      switch_route;
	disp_sel_t display_sel;
	logic      access_clear;
	logic      granted;
	logic      game_done;
	score_t    game_score;
	score_t    live_count;
	score_t    shown_score;
	logic      exit_done;

	logic [2:0] access_buttons;
	logic [2:0] game_buttons;
	logic [2:0] scores_buttons;
	password_t  access_switches;

	// each block only sees the buttons while it owns them
	assign access_buttons  = (button_route == `ARC_ROUTE_ACCESS) ? buttons : 3'b000;
	assign game_buttons    = (button_route == `ARC_ROUTE_GAME) ? buttons : 3'b000;
	assign scores_buttons  = (button_route == `ARC_ROUTE_SCORES) ? buttons : 3'b000;
	assign access_switches = switch_route ? switches : '0;

	always_comb begin
		case (display_sel)
			`ARC_DISP_GAME:   score_display = live_count;
			`ARC_DISP_SCORES: score_display = shown_score;
			default:          score_display = '0;
		endcase
	end

	process_control u_pc (
		.clk           (clk),
		.rst           (rst),
		.buttons       (buttons), // controller always sees raw buttons
		.access_fb     (granted),
		.game_fb       (game_done),
		.scoreboard_fb (exit_done),
		.button_route  (button_route),
		.switch_route  (switch_route),
		.display_sel   (display_sel),
		.lcd_control   (lcd_control),
		.led_control   (led_control),
		.access_clear  (access_clear)
	);

	access_control u_access (
		.clk          (clk),
		.rst          (rst),
		.access_clear (access_clear),
		.buttons      (access_buttons),
		.switches     (access_switches),
		.granted      (granted)
	);

	reaction_game u_game (
		.clk        (clk),
		.rst        (rst),
		.buttons    (game_buttons),
		.route      (button_route),
		.game_go    (game_go),
		.live_count (live_count),
		.score      (game_score),
		.done       (game_done)
	);

	scoreboard u_scores (
		.clk         (clk),
		.rst         (rst),
		.buttons     (scores_buttons),
		.route       (button_route),
		.done        (game_done),
		.score       (game_score),
		.shown_score (shown_score),
		.exit_done   (exit_done)
	);

endmodule

`default_nettype wire

/* sim/arcade_assert.sv */
// bound protocol checks on the console controller and the reaction game
`timescale 1ns/1ps
`default_nettype none
`include "arcade_defs.svh"

module arcade_assert (
	input logic               clk,
	input logic               rst,
	input logic               access_clear,
	input logic               done,
	input logic               game_go,
	input arcade_pkg::route_t route
);
	int clear_fails = 0;
	int done_fails = 0;
	int go_fails = 0;
	int fail_count;

	assign fail_count = clear_fails + done_fails + go_fails;

	// logout pulse is a single cycle
	clear_pulse: assert property (@(posedge clk) disable iff (!rst) !access_clear |=> access_clear)
		else begin
			clear_fails++;
			$error("access_clear stayed low longer than one cycle");
		end

	done_pulse: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
		else begin
			done_fails++;
			$error("done stayed high longer than one cycle");
		end

	go_in_game: assert property (@(posedge clk) disable iff (!rst)
		$rose(game_go) |-> route == `ARC_ROUTE_GAME)
		else begin
			go_fails++;
			$error("game_go rose outside the game route");
		end

endmodule

bind process_control arcade_assert pc_chk_i (
	.clk          (clk),
	.rst          (rst),
	.access_clear (access_clear),
	.done         (1'b0),
	.game_go      (1'b0),
	.route        (button_route)
);

bind reaction_game arcade_assert game_chk_i (
	.clk          (clk),
	.rst          (rst),
	.access_clear (1'b1),
	.done         (done),
	.game_go      (game_go),
	.route        (route)
);

`default_nettype wire

/* sim/arcade_tb.sv */
// arcade console testbench with LFSR stimulus, a reference model of the stages and scores
`timescale 1ns/1ps
`default_nettype none
`include "arcade_defs.svh"

module arcade_tb;
	import arcade_pkg::*;

	logic       clk;
	logic       rst;
	logic [2:0] buttons;
	logic [7:0] switches;
	lcd_code_t  lcd_control;
	led_code_t  led_control;
	logic       game_go;
	score_t     score_display;

	logic [15:0] rnd;          // stimulus lfsr state
	int          errors;
	int          checks;
	int          test_errors;  // errors at the start of the current test
	pc_state_t   stage;        // model of the console stage
	logic        granted_m;
	int          last_score;
	int          best_score;
	int          mode;

	arcade_top dut_i (
		.clk           (clk),
		.rst           (rst),
		.buttons       (buttons),
		.switches      (switches),
		.lcd_control   (lcd_control),
		.led_control   (led_control),
		.game_go       (game_go),
		.score_display (score_display)
	);

	always #10 clk = ~clk;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	function automatic lcd_code_t lcd_of(input pc_state_t s);
		case (s)
			ST_ACCESS: lcd_of = `ARC_LCD_PASSWORD;
			ST_MENU:   lcd_of = `ARC_LCD_MENU;
			ST_GAME:   lcd_of = `ARC_LCD_PLAYING;
			ST_SCORES: lcd_of = `ARC_LCD_SCORES;
			default:   lcd_of = `ARC_LCD_WELCOME;
		endcase
	endfunction

	// led stays green through game and scoreboard
	function automatic led_code_t led_of(input pc_state_t s);
		case (s)
			ST_INIT:   led_of = `ARC_LED_OFF;
			ST_ACCESS: led_of = `ARC_LED_RED;
			default:   led_of = `ARC_LED_GREEN;
		endcase
	endfunction

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			val = (val << 1) | int'(rnd[0]);
			rnd = lfsr_next(rnd); // one step per bit
		end
	endtask

	task automatic check_val(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("ERROR t=%0t %s: got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_stage();
		check_val("lcd_control", lcd_control, lcd_of(stage));
		check_val("led_control", led_control, led_of(stage));
	endtask

	task automatic press(input logic [2:0] b);
		buttons = b;
		tick();
		buttons = 3'b000;
	endtask

	task automatic wait_lcd(input lcd_code_t code, input int limit);
		int n;
		n = 0;
		while (lcd_control != code && n < limit) begin
			tick();
			n++;
		end
		if (lcd_control != code) begin
			errors++;
			$display("timeout: lcd_control did not reach code %0d in %0d cycles", code, limit);
		end
	endtask

	task automatic report(input string name);
		$display("test %s finished with %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	// grant shows on the lcd one edge after granted rises
	task automatic submit_password(input logic [7:0] pw);
		switches = pw;
		press(3'b001);
		if (pw == `ARC_PASSWORD) begin
			granted_m = 1'b1;
		end
		check_stage(); // still at password entry
		tick();
		if (granted_m) begin
			stage = ST_MENU;
		end
		check_stage();
	endtask

	// enter password mode, try some wrong words, then the right one
	task automatic login(input int wrong_tries);
		int pw;
		press(3'b001);
		stage = ST_ACCESS;
		check_stage();
		for (int i = 0; i < wrong_tries; i++) begin
			take_bits(8, pw);
			if (pw == `ARC_PASSWORD) begin
				pw = pw ^ 1;
			end
			submit_password(8'(pw));
		end
		submit_password(`ARC_PASSWORD);
		switches = 8'h00;
	endtask

	// mode 0 normal press, 1 false start, 2 no press at all
	task automatic play_round(input int round_mode);
		int wait_n;
		int n;
		int exp_score;
		press(3'b100);
		stage = ST_GAME;
		check_stage();
		exp_score = 0;
		if (round_mode == 1) begin
			take_bits(3, wait_n); // always shorter than the go delay
			repeat (wait_n) tick();
			check_val("game_go", game_go, 0);
			buttons = 3'b100;
		end else if (round_mode == 0) begin
			n = 0;
			while (!game_go && n < 40) begin
				tick();
				n++;
			end
			if (!game_go) begin
				errors++;
				$display("timeout: game_go never rose in round mode %0d", round_mode);
			end
			take_bits(5, wait_n);
			repeat (wait_n) tick();
			check_val("score_display", score_display, wait_n); // live count
			exp_score = `ARC_SCORE_MAX - wait_n;
			buttons = 3'b100;
		end
		n = 0;
		while (!dut_i.game_done && n < 320) begin
			tick();
			buttons = 3'b000;
			n++;
		end
		buttons = 3'b000;
		if (!dut_i.game_done) begin
			errors++;
			$display("timeout: the round never finished");
		end
		check_val("game_score", dut_i.game_score, exp_score);
		check_val("game_go", game_go, 0); // drops together with done
		last_score = exp_score;
		if (exp_score > best_score) begin
			best_score = exp_score;
		end
		stage = ST_MENU;
		wait_lcd(`ARC_LCD_MENU, 4);
		check_stage();
		check_val("score_display", score_display, 0);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		buttons = 3'b000;
		switches = 8'h00;
		rnd = 16'd40;
		errors = 0;
		checks = 0;
		test_errors = 0;
		stage = ST_INIT;
		granted_m = 1'b0;
		last_score = 0;
		best_score = 0;

		repeat (3) tick();
		check_stage();
		check_val("score_display", score_display, 0);
		check_val("game_go", game_go, 0);
		rst = 1'b1;
		report("reset");

		login(3);
		report("login");

		// last round is a false start so last and best differ
		for (int r = 0; r < 20; r++) begin
			take_bits(2, mode);
			if (r == 7) begin
				mode = 2;
			end else if (mode == 0 || r == 2 || r == 19) begin
				mode = 1;
			end else begin
				mode = 0;
			end
			play_round(mode);
		end
		report("reaction rounds");

		press(3'b010);
		stage = ST_SCORES;
		check_stage();
		check_val("score_display", score_display, best_score);
		press(3'b010);
		check_val("score_display", score_display, last_score);
		press(3'b001);
		stage = ST_MENU;
		wait_lcd(`ARC_LCD_MENU, 4);
		check_stage();
		report("scoreboard");

		press(3'b001);
		stage = ST_INIT;
		granted_m = 1'b0;
		check_stage();
		login(2);
		report("logout");

		errors = errors + dut_i.u_pc.pc_chk_i.fail_count + dut_i.u_game.game_chk_i.fail_count;
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+src
src/arcade_pkg.sv
src/process_control.sv
src/access_control.sv
src/reaction_game.sv
src/scoreboard.sv
src/arcade_top.sv
sim/arcade_assert.sv
sim/arcade_tb.sv

/* Makefile */
# Verilator build and run of the arcade console testbench

VERILATOR ?= verilator
TOP       ?= arcade_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# pass only if the testbench printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
